//--- filelist.f
logic/usb_ctl_pkg.sv
logic/setup_capture.sv
logic/desc_rom.sv
logic/ctl_pipe0.sv
logic/desc_length_limit.sv
logic/usb_ctl_top.sv
dv/usb_ctl_chk.sv
dv/usb_ctl_tb.sv

//--- dv/usb_ctl_tb.sv
`timescale 1ns/100ps

module usb_ctl_tb;

  import usb_ctl_pkg::*;

  localparam logic [15:0] VID = 16'hFACE;
  localparam logic [15:0] PID = 16'h0BDE;
  localparam integer PROD_LEN = 4;
  localparam logic [8*PROD_LEN-1:0] PROD_TEXT = "FPGA";
  // Product name as characters, first character at index 0
  localparam string PROD_NAME = "FPGA";
  localparam integer WAIT_LIMIT = 2000;
  localparam logic [15:0] LFSR_SEED = 16'd45719;

  logic       clock;
  logic       reset;
  logic       setup_valid;
  logic       setup_first;
  logic [7:0] setup_data;
  logic       select;
  logic       error;
  logic       configured;
  logic [6:0] usb_addr;
  logic [7:0] usb_conf;
  logic       m_tvalid;
  logic       m_tready;
  logic       m_tlast;
  logic [7:0] m_tdata;
  logic [15:0] lfsr;

  // Reply being received, set by the stimulus and used by the compare process
  string     test_name = "reset";
  req_kind_e exp_kind = REQ_NONE;
  int        exp_index = 0;
  int        exp_len = 0;
  int        rx_count = 0;
  int        checks = 0;
  int        errors = 0;
  int        timeouts = 0;

  usb_ctl_top #(
    .VENDOR_ID   (VID),
    .PRODUCT_ID  (PID),
    .HIGH_SPEED  (1),
    .PRODUCT_LEN (PROD_LEN),
    .PRODUCT     (PROD_TEXT)
  ) UUT (
    .clock         (clock),
    .reset         (reset),
    .setup_valid_i (setup_valid),
    .setup_first_i (setup_first),
    .setup_data_i  (setup_data),
    .select_i      (select),
    .error_o       (error),
    .configured_o  (configured),
    .usb_addr_o    (usb_addr),
    .usb_conf_o    (usb_conf),
    .m_tvalid_o    (m_tvalid),
    .m_tready_i    (m_tready),
    .m_tlast_o     (m_tlast),
    .m_tdata_o     (m_tdata)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // Descriptor length from the standard layouts
  function automatic int reply_length(input req_kind_e kind, input int index);
    if (kind == REQ_GET_DEVICE) return 18;
    if (kind == REQ_GET_CONFIG) return CONFIG_DESC_LEN;
    if (index == 0) return 4;
    return 2 + 2 * PROD_LEN;
  endfunction

  // Reference descriptor byte at a position of the reply
  function automatic logic [7:0] expected_byte(input req_kind_e kind, input int index,
                                               input int pos);
    int c;
    c = (pos - 2) / 2;
    if (kind == REQ_GET_CONFIG) return CONFIG_DESC[8*pos+:8];
    if (kind == REQ_GET_DEVICE) begin
      case (pos)
        0: return 8'h12;
        1: return 8'h01;
        // bcdUSB 2.00 for high speed
        3: return 8'h02;
        4: return 8'hFF;
        7: return 8'h40;
        8: return VID[7:0];
        9: return VID[15:8];
        10: return PID[7:0];
        11: return PID[15:8];
        // iProduct and bNumConfigurations
        15: return 8'h01;
        17: return 8'h01;
        default: return 8'h00;
      endcase
    end
    if (index == 0) begin
      case (pos)
        0: return 8'h04;
        1: return 8'h03;
        2: return 8'h09;
        default: return 8'h04;
      endcase
    end
    if (pos == 0) return 8'(2 + 2 * PROD_LEN);
    if (pos == 1) return 8'h03;
    // UTF-16LE, odd bytes are the zero high half
    if (pos % 2 == 1) return 8'h00;
    return PROD_NAME[c];
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic finish_run();
    int total;
    total = errors + timeouts + UUT.u_chk.assert_fails;
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, UUT.u_chk.assert_fails);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout while waiting for %s", what);
  endtask

  // Ready from the LFSR, one bit per cycle
  initial begin
    m_tready = 1'b0;
    lfsr = LFSR_SEED;
    forever begin
      @(posedge clock);
      m_tready <= lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  end

  // Compare each accepted byte and its last flag
  always @(posedge clock) begin
    if (!reset && m_tvalid && m_tready) begin
      if (rx_count >= exp_len) begin
        errors++;
        $display("%s: stream byte %0d arrived beyond the expected reply", test_name, rx_count);
      end else begin
        check_value($sformatf("%s byte %0d", test_name, rx_count),
                    expected_byte(exp_kind, exp_index, rx_count), m_tdata);
        check_value($sformatf("%s last %0d", test_name, rx_count),
                    (rx_count == exp_len - 1), m_tlast);
      end
      rx_count <= rx_count + 1;
    end
  end

  // Eight SETUP bytes on consecutive cycles, 16-bit fields little-endian
  task automatic send_setup(input logic [7:0] req_type, input logic [7:0] req,
                            input logic [15:0] value, input logic [15:0] length);
    logic [7:0] bytes [8];
    bytes[0] = req_type;
    bytes[1] = req;
    bytes[2] = value[7:0];
    bytes[3] = value[15:8];
    bytes[4] = 8'h00;
    bytes[5] = 8'h00;
    bytes[6] = length[7:0];
    bytes[7] = length[15:8];
    for (int i = 0; i < 8; i++) begin
      @(posedge clock);
      setup_valid <= 1'b1;
      setup_first <= (i == 0);
      setup_data <= bytes[i];
    end
    @(posedge clock);
    setup_valid <= 1'b0;
    setup_first <= 1'b0;
    setup_data <= 8'h00;
  endtask

  task automatic open_request(input string name, input req_kind_e kind, input int index,
                              input int len);
    @(posedge clock);
    test_name <= name;
    exp_kind <= kind;
    exp_index <= index;
    exp_len <= len;
    rx_count <= 0;
    select <= 1'b1;
  endtask

  task automatic run_get(input string name, input logic [7:0] dtype, input logic [7:0] dindex,
                         input logic [15:0] length);
    req_kind_e kind;
    int want;
    int cycles;
    case (dtype)
      DTYPE_DEVICE: kind = REQ_GET_DEVICE;
      DTYPE_CONFIG: kind = REQ_GET_CONFIG;
      default: kind = REQ_GET_STRING;
    endcase
    want = reply_length(kind, dindex);
    if (length < want) want = length;
    open_request(name, kind, dindex, want);
    send_setup(8'h80, BREQ_GET_DESCRIPTOR, {dtype, dindex}, length);
    cycles = 0;
    while (rx_count < want && cycles < WAIT_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    if (rx_count < want) report_timeout({"the reply of ", name});
    // Valid drops right after the last transfer
    check_value({name, " valid after last"}, 0, m_tvalid);
    @(posedge clock);
    select <= 1'b0;
    @(posedge clock);
  endtask

  task automatic run_set(input string name, input logic [7:0] req, input logic [7:0] value);
    int cycles;
    open_request(name, REQ_NONE, 0, 0);
    send_setup(8'h00, req, {8'h00, value}, 16'h0000);
    cycles = 0;
    while (usb_addr != value[6:0] && usb_conf != value && cycles < WAIT_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    if (cycles >= WAIT_LIMIT) report_timeout({"the update of ", name});
    @(posedge clock);
    select <= 1'b0;
    @(posedge clock);
  endtask

  task automatic run_unsupported(input string name, input logic [7:0] req_type,
                                 input logic [7:0] req, input logic [15:0] value);
    int cycles;
    open_request(name, REQ_NONE, 0, 0);
    send_setup(req_type, req, value, 16'h00FF);
    cycles = 0;
    while (!error && cycles < WAIT_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    if (!error) report_timeout({"error on ", name});
    // Error is a level that holds while selected
    @(posedge clock);
    check_value({name, " error held"}, 1, error);
    check_value({name, " valid"}, 0, m_tvalid);
    select <= 1'b0;
    cycles = 0;
    while (error && cycles < WAIT_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    if (error) report_timeout({"error to clear on ", name});
    // Cleared on the first edge that sees the deselect, observed one edge later
    check_value({name, " error clear cycles"}, 2, cycles);
  endtask

  initial begin
    reset = 1'b1;
    select = 1'b0;
    setup_valid = 1'b0;
    setup_first = 1'b0;
    setup_data = 8'h00;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    check_value("reset valid", 0, m_tvalid);
    check_value("reset error", 0, error);
    check_value("reset configured", 0, configured);
    check_value("reset address", 0, usb_addr);
    check_value("reset configuration", 0, usb_conf);

    run_get("device descriptor", DTYPE_DEVICE, 8'd0, 16'd64);
    run_get("config truncated", DTYPE_CONFIG, 8'd0, 16'd9);
    run_get("config full", DTYPE_CONFIG, 8'd0, 16'd255);
    run_get("language id", DTYPE_STRING, 8'd0, 16'd255);
    run_get("product string", DTYPE_STRING, 8'd1, 16'd255);

    run_set("set address", BREQ_SET_ADDRESS, 8'h2A);
    check_value("set address value", 8'h2A, usb_addr);
    check_value("set address configured", 0, configured);
    run_set("set configuration", BREQ_SET_CONFIGURATION, 8'h01);
    check_value("set configuration value", 1, usb_conf);
    check_value("set configuration configured", 1, configured);
    check_value("address kept", 8'h2A, usb_addr);

    // Vendor type bits, then a string index with no descriptor
    run_unsupported("vendor request", 8'hC0, 8'h01, 16'h0000);
    run_unsupported("string index 5", 8'h80, BREQ_GET_DESCRIPTOR, {DTYPE_STRING, 8'd5});

    repeat (4) @(posedge clock);
    finish_run();
  end

endmodule

//--- dv/usb_ctl_chk.sv
`timescale 1ns/100ps

module usb_ctl_chk (
  input logic                    clock,
  input logic                    reset,
  input logic                    valid_i,
  input logic                    ready_i,
  input logic                    last_i,
  input logic [7:0]              data_i,
  input logic                    error_i,
  input logic                    configured_i,
  input logic [6:0]              addr_i,
  input logic [7:0]              conf_i,
  input usb_ctl_pkg::pipe_state_e state_i
);

  import usb_ctl_pkg::*;

  // Failed assertions, read by the testbench at the end of the run
  int unsigned assert_fails = 0;

  // A stalled byte stays on the stream unchanged
  hold_under_stall: assert property (
    @(posedge clock) disable iff (reset)
    (valid_i && !ready_i) |=> (valid_i && $stable(data_i) && $stable(last_i))
  ) else begin
    assert_fails++;
    $error("stream byte or last flag changed while stalled");
  end

  // No reply while a request is refused
  no_valid_with_error: assert property (
    @(posedge clock) disable iff (reset)
    !(valid_i && error_i)
  ) else begin
    assert_fails++;
    $error("stream valid and error high together");
  end

  // Control outputs and FSM cleared one cycle after reset
  reset_state: assert property (
    @(posedge clock)
    reset |=> (!valid_i && !error_i && !configured_i && addr_i == 7'd0 &&
               conf_i == 8'd0 && state_i == ST_IDLE)
  ) else begin
    assert_fails++;
    $error("control outputs not cleared after reset");
  end

endmodule

bind usb_ctl_top usb_ctl_chk u_chk (
  .clock        (clock),
  .reset        (reset),
  .valid_i      (m_tvalid_o),
  .ready_i      (m_tready_i),
  .last_i       (m_tlast_o),
  .data_i       (m_tdata_o),
  .error_i      (error_o),
  .configured_i (configured_o),
  .addr_i       (usb_addr_o),
  .conf_i       (usb_conf_o),
  .state_i      (u_pipe0.state_q)
);

//--- logic/usb_ctl_top.sv
`timescale 1ns/100ps

module usb_ctl_top #(
  parameter logic [15:0] VENDOR_ID = 16'hFACE,
  parameter logic [15:0] PRODUCT_ID = 16'h0BDE,
  parameter integer HIGH_SPEED = 1,
  parameter integer PRODUCT_LEN = 0,
  parameter PRODUCT = ""
) (
  input  logic       clock,
  input  logic       reset,

  input  logic       setup_valid_i,
  input  logic       setup_first_i,
  input  logic [7:0] setup_data_i,

  input  logic       select_i,
  output logic       error_o,

  output logic       configured_o,
  output logic [6:0] usb_addr_o,
  output logic [7:0] usb_conf_o,

  // Descriptor byte stream
  output logic       m_tvalid_o,
  input  logic       m_tready_i,
  output logic       m_tlast_o,
  output logic [7:0] m_tdata_o
);

  import usb_ctl_pkg::*;

  localparam integer ROM_ABITS = rom_abits(PRODUCT_LEN);

  logic        start;
  logic        stop;
  logic [7:0]  req_type;
  logic [7:0]  req_args;
  logic [15:0] req_value;
  logic [15:0] req_length;
  logic        load;
  req_kind_e   kind;
  logic [7:0]  str_index;
  logic        advance;
  logic        desc_end;

  // wIndex has no use in device requests
  setup_capture u_capture (
    .clock         (clock),
    .reset         (reset),
    .setup_valid_i (setup_valid_i),
    .setup_first_i (setup_first_i),
    .setup_data_i  (setup_data_i),
    .start_o       (start),
    .req_type_o    (req_type),
    .req_args_o    (req_args),
    .req_value_o   (req_value),
    .req_index_o   (),
    .req_length_o  (req_length)
  );

  ctl_pipe0 #(
    .ROM_ABITS (ROM_ABITS)
  ) u_pipe0 (
    .clock        (clock),
    .reset        (reset),
    .select_i     (select_i),
    .start_i      (start),
    .stop_i       (stop),
    .req_type_i   (req_type),
    .req_args_i   (req_args),
    .req_value_i  (req_value),
    .load_o       (load),
    .kind_o       (kind),
    .str_index_o  (str_index),
    .advance_o    (advance),
    .m_tvalid_o   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .error_o      (error_o),
    .configured_o (configured_o),
    .usb_addr_o   (usb_addr_o),
    .usb_conf_o   (usb_conf_o)
  );

  desc_rom #(
    .VENDOR_ID   (VENDOR_ID),
    .PRODUCT_ID  (PRODUCT_ID),
    .HIGH_SPEED  (HIGH_SPEED),
    .PRODUCT_LEN (PRODUCT_LEN),
    .PRODUCT     (PRODUCT)
  ) u_rom (
    .clock       (clock),
    .load_i      (load),
    .kind_i      (kind),
    .str_index_i (str_index),
    .advance_i   (advance),
    .data_o      (m_tdata_o),
    .desc_end_o  (desc_end)
  );

  // Truncates each reply to wLength
  desc_length_limit u_limit (
    .clock        (clock),
    .reset        (reset),
    .start_i      (start),
    .req_length_i (req_length),
    .desc_end_i   (desc_end),
    .m_tvalid_i   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .m_tlast_o    (m_tlast_o),
    .stop_o       (stop)
  );

endmodule

//--- logic/desc_length_limit.sv
`timescale 1ns/100ps

module desc_length_limit (
  input  logic        clock,
  input  logic        reset,

  input  logic        start_i,
  input  logic [15:0] req_length_i,

  input  logic        desc_end_i,
  input  logic        m_tvalid_i,
  input  logic        m_tready_i,

  output logic        m_tlast_o,
  output logic        stop_o
);

  logic [15:0] count_q;
  logic [15:0] final_index;
  logic        xfer;

  assign xfer = m_tvalid_i && m_tready_i;

  // Position of the last byte the host asked for
  assign final_index = req_length_i - 16'd1;

  // Bytes already moved in this reply
  always_ff @(posedge clock) begin
    if (reset || start_i) begin
      count_q <= 16'd0;
    end else if (xfer) begin
      count_q <= count_q + 16'd1;
    end
  end

  // Descriptor end or wLength, whichever comes first
  assign m_tlast_o = desc_end_i || (count_q == final_index);

  // Final byte accepted
  assign stop_o = m_tlast_o && xfer;

endmodule

//--- logic/ctl_pipe0.sv
`timescale 1ns/100ps

module ctl_pipe0 #(
  parameter integer ROM_ABITS = 6
) (
  input  logic                   clock,
  input  logic                   reset,

  input  logic                   select_i,
  input  logic                   start_i,
  input  logic                   stop_i,
  input  logic [7:0]             req_type_i,
  input  logic [7:0]             req_args_i,
  input  logic [15:0]            req_value_i,

  // Descriptor ROM control
  output logic                   load_o,
  output usb_ctl_pkg::req_kind_e kind_o,
  output logic [7:0]             str_index_o,
  output logic                   advance_o,

  output logic                   m_tvalid_o,
  input  logic                   m_tready_i,

  output logic                   error_o,
  output logic                   configured_o,
  output logic [6:0]             usb_addr_o,
  output logic [7:0]             usb_conf_o
);

  import usb_ctl_pkg::*;

  pipe_state_e state_q;
  req_kind_e kind;
  logic std_dev_req;
  logic dir_in;
  logic [ROM_ABITS-1:0] sent_q;

  // Standard type, device recipient
  assign std_dev_req = (req_type_i[6:5] == 2'b00) && (req_type_i[4:0] == 5'd0);
  assign dir_in = req_type_i[7];

  // Request decode
  always_comb begin
    kind = REQ_NONE;
    if (std_dev_req) begin
      if (req_args_i == BREQ_GET_DESCRIPTOR && dir_in) begin
        case (req_value_i[15:8])
          DTYPE_DEVICE: kind = REQ_GET_DEVICE;
          DTYPE_CONFIG: kind = REQ_GET_CONFIG;
          // Only the language table and the product string exist
          DTYPE_STRING: kind = (req_value_i[7:0] <= 8'd1) ? REQ_GET_STRING : REQ_NONE;
          default: kind = REQ_NONE;
        endcase
      end else if (req_args_i == BREQ_SET_ADDRESS && !dir_in) begin
        kind = REQ_SET_ADDR;
      end else if (req_args_i == BREQ_SET_CONFIGURATION && !dir_in) begin
        kind = REQ_SET_CONF;
      end
    end
  end

  // ROM load in the start cycle
  assign load_o = select_i && start_i && (state_q == ST_IDLE);
  assign kind_o = kind;
  assign str_index_o = req_value_i[7:0];

  assign m_tvalid_o = (state_q == ST_GET_DESC);
  assign advance_o = m_tvalid_o && m_tready_i;

  // Bytes sent in this reply, a runaway stops at the end of the address space
  always_ff @(posedge clock) begin
    if (reset || load_o) begin
      sent_q <= '0;
    end else if (advance_o) begin
      sent_q <= sent_q + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
      error_o <= 1'b0;
      configured_o <= 1'b0;
      usb_addr_o <= 7'd0;
      usb_conf_o <= 8'd0;
    end else if (!select_i) begin
      // Deselect ends the transfer and clears the error
      state_q <= ST_IDLE;
      error_o <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            error_o <= (kind == REQ_NONE);
            case (kind)
              REQ_GET_DEVICE, REQ_GET_CONFIG, REQ_GET_STRING: state_q <= ST_GET_DESC;
              REQ_SET_ADDR: begin
                // Address takes effect at once
                usb_addr_o <= req_value_i[6:0];
                state_q <= ST_SET_ADDR;
              end
              REQ_SET_CONF: begin
                usb_conf_o <= req_value_i[7:0];
                configured_o <= (req_value_i[7:0] != 8'd0);
                state_q <= ST_SET_CONF;
              end
              default: state_q <= ST_IDLE;
            endcase
          end
        end
        ST_GET_DESC: begin
          if (stop_i || (advance_o && (&sent_q))) begin
            state_q <= ST_IDLE;
          end
        end
        // SET states hold until deselect
        default: state_q <= state_q;
      endcase
    end
  end

endmodule

//--- logic/desc_rom.sv
`timescale 1ns/100ps

module desc_rom #(
  parameter logic [15:0] VENDOR_ID = 16'hFACE,
  parameter logic [15:0] PRODUCT_ID = 16'h0BDE,
  parameter integer HIGH_SPEED = 1,
  parameter integer PRODUCT_LEN = 0,
  parameter PRODUCT = ""
) (
  input  logic                  clock,
  input  logic                  load_i,
  input  usb_ctl_pkg::req_kind_e kind_i,
  input  logic [7:0]            str_index_i,
  input  logic                  advance_i,
  output logic [7:0]            data_o,
  output logic                  desc_end_o
);

  import usb_ctl_pkg::*;

  localparam integer ROM_SIZE = rom_size(PRODUCT_LEN);
  localparam integer ROM_ABITS = rom_abits(PRODUCT_LEN);
  localparam integer ROM_DEPTH = 1 << ROM_ABITS;

  // Descriptor start addresses
  localparam integer CONF_START = DEVICE_DESC_LEN;
  localparam integer LANG_START = CONF_START + CONFIG_DESC_LEN;
  localparam integer PROD_START = LANG_START + 4;

  localparam logic [15:0] BCD_USB = (HIGH_SPEED != 0) ? 16'h0200 : 16'h0110;
  localparam logic [7:0] I_PRODUCT = (PRODUCT_LEN > 0) ? 8'h01 : 8'h00;

  // Device descriptor, vendor class, 64-byte EP0, one configuration
  localparam logic [DEVICE_DESC_LEN*8-1:0] DEVICE_DESC = {
    8'h01, 8'h00, I_PRODUCT, 8'h00,
    16'h0000, PRODUCT_ID, VENDOR_ID,
    8'h40, 8'h00, 8'h00, 8'hFF,
    BCD_USB, 8'h01, 8'h12
  };

  // Language ID descriptor, US English
  localparam logic [31:0] LANG_DESC = {16'h0409, 8'h03, 8'h04};

  function automatic logic [7:0] rom_byte(input integer a);
    integer k;
    k = a - PROD_START;
    if (a < CONF_START) return DEVICE_DESC[8*a+:8];
    if (a < LANG_START) return CONFIG_DESC[8*(a-CONF_START)+:8];
    if (a < PROD_START) return LANG_DESC[8*(a-LANG_START)+:8];
    if (PRODUCT_LEN == 0 || a >= ROM_SIZE) return 8'h00;
    if (k == 0) return 8'(2 + 2 * PRODUCT_LEN);
    if (k == 1) return 8'h03;
    // UTF-16LE, high byte of each character is zero
    if (k[0]) return 8'h00;
    return PRODUCT[8*(PRODUCT_LEN-(k-2)/2)-1-:8];
  endfunction

  logic [7:0] rom [ROM_DEPTH];
  logic       rom_end [ROM_DEPTH];
  logic [ROM_ABITS-1:0] addr_q;

  // Contents fixed at elaboration, unused space reads as an end byte
  for (genvar i = 0; i < ROM_DEPTH; i++) begin : g_rom
    assign rom[i] = rom_byte(i);
    assign rom_end[i] = (i == CONF_START - 1) || (i == LANG_START - 1) ||
                        (PRODUCT_LEN > 0 && (i == PROD_START - 1)) || (i >= ROM_SIZE - 1);
  end

  // Read address, loaded per request and stepped per transfer
  always_ff @(posedge clock) begin
    if (load_i) begin
      case (kind_i)
        REQ_GET_CONFIG: addr_q <= ROM_ABITS'(CONF_START);
        REQ_GET_STRING: addr_q <= (str_index_i == 8'd0) ? ROM_ABITS'(LANG_START) :
                                                          ROM_ABITS'(PROD_START);
        default: addr_q <= '0;
      endcase
    end else if (advance_i) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  assign data_o = rom[addr_q];
  assign desc_end_o = rom_end[addr_q];

endmodule

//--- logic/setup_capture.sv
`timescale 1ns/100ps

module setup_capture (
  input  logic        clock,
  input  logic        reset,

  // SETUP packet bytes, byte 0 flagged by setup_first_i
  input  logic        setup_valid_i,
  input  logic        setup_first_i,
  input  logic [7:0]  setup_data_i,

  output logic        start_o,
  output logic [7:0]  req_type_o,
  output logic [7:0]  req_args_o,
  output logic [15:0] req_value_o,
  output logic [15:0] req_index_o,
  output logic [15:0] req_length_o
);

  logic [2:0] count_q;
  logic [2:0] slot;

  // A first byte always lands in slot 0, whatever the count says
  assign slot = setup_first_i ? 3'd0 : count_q;

  // Byte counter and start pulse
  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= 3'd0;
      start_o <= 1'b0;
    end else begin
      start_o <= 1'b0;
      if (setup_valid_i) begin
        count_q <= slot + 3'd1;
        // Eighth byte completes the request
        start_o <= (slot == 3'd7);
      end
    end
  end

  // Field steering, 16-bit fields little-endian
  always_ff @(posedge clock) begin
    if (setup_valid_i) begin
      case (slot)
        3'd0: req_type_o <= setup_data_i;
        3'd1: req_args_o <= setup_data_i;
        3'd2: req_value_o[7:0] <= setup_data_i;
        3'd3: req_value_o[15:8] <= setup_data_i;
        3'd4: req_index_o[7:0] <= setup_data_i;
        3'd5: req_index_o[15:8] <= setup_data_i;
        3'd6: req_length_o[7:0] <= setup_data_i;
        default: req_length_o[15:8] <= setup_data_i;
      endcase
    end
  end

endmodule

//--- logic/usb_ctl_pkg.sv
package usb_ctl_pkg;

  // Decoded standard device request
  typedef enum logic [2:0] {
    REQ_NONE,
    REQ_GET_DEVICE,
    REQ_GET_CONFIG,
    REQ_GET_STRING,
    REQ_SET_ADDR,
    REQ_SET_CONF
  } req_kind_e;

  // Endpoint-0 control pipe states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_GET_DESC,
    ST_SET_ADDR,
    ST_SET_CONF
  } pipe_state_e;

  // bRequest codes
  localparam logic [7:0] BREQ_SET_ADDRESS = 8'd5;
  localparam logic [7:0] BREQ_GET_DESCRIPTOR = 8'd6;
  localparam logic [7:0] BREQ_SET_CONFIGURATION = 8'd9;

  // Descriptor types, carried in the wValue high byte
  localparam logic [7:0] DTYPE_DEVICE = 8'd1;
  localparam logic [7:0] DTYPE_CONFIG = 8'd2;
  localparam logic [7:0] DTYPE_STRING = 8'd3;

  localparam integer DEVICE_DESC_LEN = 18;
  localparam integer CONFIG_DESC_LEN = 18;

  // Configuration plus one interface, byte 0 in the low bits
  localparam logic [CONFIG_DESC_LEN*8-1:0] CONFIG_DESC = {
    // Interface descriptor, no endpoints and no class
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
    8'h04,
    8'h09,
    // Configuration descriptor, self-powered at 100 mA
    8'h32, 8'hC0, 8'h00, 8'h01, 8'h01,
    16'h0012,
    8'h02,
    8'h09
  };

  // Total ROM bytes, the two string descriptors only with a product string
  function automatic integer rom_size(input integer product_len);
    return DEVICE_DESC_LEN + CONFIG_DESC_LEN + ((product_len > 0) ? 6 + 2 * product_len : 0);
  endfunction

  // Address width with room for one byte past the end
  function automatic integer rom_abits(input integer product_len);
    return $clog2(rom_size(product_len) + 1);
  endfunction

endpackage
